//--- compile.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/branch_dir_predictor.sv
hdl/branch_target_calc.sv
hdl/fetch_sequencer.sv
hdl/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv

//--- hdl/branch_dir_predictor.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module branch_dir_predictor
	import fetch_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	// Lookup by returned PC
	input  wire       bht_idx_t i_rd_idx,
	output logic      o_taken,
	// Training from execute
	input  wire       resolve_t i_resolve
);

	localparam int IDX_W = $bits(bht_idx_t);

	// Saturating counters, 0..1 not taken, 2..3 taken
	logic [1:0] cnt [`FETCH_BHT_ENTRIES];

	bht_idx_t   upd_idx;
	logic [1:0] upd_old;
	logic [1:0] upd_new;

	// Upper counter bit gives the direction
	// Read sees the pre-update value
	assign o_taken = cnt[i_rd_idx][1];

	// Word-aligned PC, drop the low two bits
	assign upd_idx = i_resolve.pc[IDX_W+1:2];
	assign upd_old = cnt[upd_idx];

	// Next count, clamped at both ends
	always_comb begin
		upd_new = upd_old;
		if (i_resolve.taken) begin
			if (upd_old != 2'd3) begin
				upd_new = upd_old + 2'd1;
			end
		end else begin
			if (upd_old != 2'd0) begin
				upd_new = upd_old - 2'd1;
			end
		end
	end

	// One update per cycle at most
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Weakly not taken
			for (int i = 0; i < `FETCH_BHT_ENTRIES; i++) begin
				cnt[i] <= 2'd1;
			end
		end else if (i_resolve.valid) begin
			cnt[upd_idx] <= upd_new;
		end
	end

endmodule

`default_nettype wire

//--- hdl/branch_target_calc.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module branch_target_calc
	import fetch_pkg::*;
(
	input  wire         imem_rsp_t i_rsp,
	output logic        o_is_branch,
	output logic        o_is_jal,
	output logic [31:0] o_target
);

	instr_u      ins;
	logic [31:0] b_imm;
	logic [31:0] j_imm;
	logic [31:0] offset;

	assign ins = i_rsp.instr;

	// Opcode sits in the same bits in both views
	assign o_is_branch = (ins.b.opcode == `FETCH_OP_BRANCH);
	assign o_is_jal    = (ins.j.opcode == `FETCH_OP_JAL);

	// B immediate, 13 bits signed, bit 0 always zero
	assign b_imm = {
		{19{ins.b.imm12}},
		ins.b.imm12,
		ins.b.imm11,
		ins.b.imm10_5,
		ins.b.imm4_1,
		1'b0
	};

	// J immediate, 21 bits signed
	assign j_imm = {
		{11{ins.j.imm20}},
		ins.j.imm20,
		ins.j.imm19_12,
		ins.j.imm11,
		ins.j.imm10_1,
		1'b0
	};

	// Pick the view that matches the opcode
	assign offset = o_is_jal ? j_imm : b_imm;

	// PC-relative, relative to the echoed fetch PC
	assign o_target = i_rsp.pc + offset;

endmodule

`default_nettype wire

//--- hdl/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// First fetch address out of reset
`define FETCH_PC_RESET 32'h0000_0000

// Request slots toward instruction memory
`define FETCH_MEM_CREDITS 4

// Slots in the decode input buffer
`define FETCH_DEC_CREDITS 2

// Two-bit counters in the direction table
// Indexed by PC[5:2]
`define FETCH_BHT_ENTRIES 16

// RV32I major opcodes seen by predecode
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_JAL 7'b1101111

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

//--- hdl/fetch_pkg.sv
`default_nettype none
`include "fetch_macros.svh"

package fetch_pkg;

	// Wrong-path tag, bumped on every PC redirect
	typedef logic [1:0] epoch_t;

	// Direction table index
	typedef logic [$clog2(`FETCH_BHT_ENTRIES)-1:0] bht_idx_t;

	// Fetch request to instruction memory
	typedef struct packed {
		logic [31:0] pc;
		epoch_t      epoch;
	} imem_req_t;

	// Memory echoes PC and epoch with the word
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		epoch_t      epoch;
	} imem_rsp_t;

	// Word handed to decode, 65 bits
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic        pred_taken;
	} fetch_out_t;

	// From execute, branch mispredict, jump or trap
	typedef struct packed {
		logic        valid;
		logic        trap;
		logic [31:0] target;
	} redirect_t;

	// Resolved conditional branch for training
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        taken;
	} resolve_t;

	// B-type layout, immediate split across the word
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// J-type layout
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// Same word, two decodings
	typedef union packed {
		b_fmt_t b;
		j_fmt_t j;
	} instr_u;

endpackage

`default_nettype wire

//--- hdl/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_sequencer
	import fetch_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	// Memory request channel
	output imem_req_t   o_imem_req,
	output logic        o_imem_req_valid,
	input  wire         imem_rsp_t i_imem_rsp,
	input  wire         i_imem_rsp_valid,
	// Decode channel
	input  wire         i_dec_credit,
	output fetch_out_t  o_fetch,
	output logic        o_fetch_valid,
	// Execute redirect
	input  wire         redirect_t i_redirect,
	// Predictor and predecode results
	output bht_idx_t    o_bht_idx,
	input  wire         i_pred_taken,
	input  wire         i_is_branch,
	input  wire         i_is_jal,
	input  wire  [31:0] i_target
);

	// One counter width covers both credit pools
	localparam int CRED_MAX = (`FETCH_MEM_CREDITS > `FETCH_DEC_CREDITS) ?
		`FETCH_MEM_CREDITS : `FETCH_DEC_CREDITS;
	localparam int CRED_W = $clog2(CRED_MAX + 1);
	localparam logic [CRED_W-1:0] MEM_FULL = CRED_W'(`FETCH_MEM_CREDITS);
	localparam logic [CRED_W-1:0] DEC_FULL = CRED_W'(`FETCH_DEC_CREDITS);
	localparam int IDX_W = $bits(bht_idx_t);

	logic [31:0]       pc;
	epoch_t            epoch;
	logic              started;
	logic [CRED_W-1:0] mem_credits;
	logic [CRED_W-1:0] dec_credits;
	logic [CRED_W-1:0] in_flight;
	logic              req_fire;
	logic              rsp_match;
	logic              fwd;
	logic              fetch_pred;
	logic              pred_jump;

	// Requests outstanding at memory
	assign in_flight = MEM_FULL - mem_credits;

	// Issue only if every outstanding word already has a decode slot
	assign req_fire = started && (mem_credits != '0) && (in_flight < dec_credits);

	assign o_imem_req_valid = req_fire;
	assign o_imem_req.pc    = pc;
	assign o_imem_req.epoch = epoch;

	// Stale epoch means wrong path
	assign rsp_match = i_imem_rsp_valid && (i_imem_rsp.epoch == epoch);

	// Redirect in the same cycle kills the response too
	assign fwd = rsp_match && !i_redirect.valid;

	// JAL always, branch only on a taken counter
	assign fetch_pred = i_is_jal || (i_is_branch && i_pred_taken);
	assign pred_jump  = fwd && fetch_pred;

	// Table lookup follows the returning word
	assign o_bht_idx = i_imem_rsp.pc[IDX_W+1:2];

	// Hold off requests for the first cycle out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			started <= 1'b0;
		end else begin
			started <= 1'b1;
		end
	end

	// Next PC, redirect beats prediction beats sequential
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `FETCH_PC_RESET;
		end else if (i_redirect.valid) begin
			pc <= i_redirect.target;
		end else if (pred_jump) begin
			pc <= i_target;
		end else if (req_fire) begin
			pc <= pc + 32'd4;
		end
	end

	// Any PC change retires whatever is still in flight
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			epoch <= '0;
		end else if (i_redirect.valid || pred_jump) begin
			epoch <= epoch + 2'd1;
		end
	end

	// Memory credits, spent per request
	// Returned per response, wrong path included
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_credits <= MEM_FULL;
		end else begin
			case ({req_fire, i_imem_rsp_valid})
				2'b10:   mem_credits <= mem_credits - 1'b1;
				2'b01:   mem_credits <= mem_credits + 1'b1;
				default: mem_credits <= mem_credits;
			endcase
		end
	end

	// Decode credits, spent as a word is forwarded
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_credits <= DEC_FULL;
		end else begin
			case ({fwd, i_dec_credit})
				2'b10:   dec_credits <= dec_credits - 1'b1;
				2'b01:   dec_credits <= dec_credits + 1'b1;
				default: dec_credits <= dec_credits;
			endcase
		end
	end

	// One cycle from response to decode
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_fetch_valid <= 1'b0;
		end else begin
			o_fetch_valid <= fwd;
		end
	end

	// Output word, a bubble shows NOP at the reset PC
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_fetch.pc         <= `FETCH_PC_RESET;
			o_fetch.instr      <= `FETCH_NOP;
			o_fetch.pred_taken <= 1'b0;
		end else if (fwd) begin
			o_fetch.pc         <= i_imem_rsp.pc;
			o_fetch.instr      <= i_imem_rsp.instr;
			o_fetch.pred_taken <= fetch_pred;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import fetch_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	// Instruction memory
	output imem_req_t  o_imem_req,
	output logic       o_imem_req_valid,
	input  wire        imem_rsp_t i_imem_rsp,
	input  wire        i_imem_rsp_valid,
	// Decode
	input  wire        i_dec_credit,
	output fetch_out_t o_fetch,
	output logic       o_fetch_valid,
	// Execute
	input  wire        redirect_t i_redirect,
	input  wire        resolve_t i_resolve
);

	bht_idx_t    bht_idx;
	logic        pred_taken;
	logic        is_branch;
	logic        is_jal;
	logic [31:0] target;

	// Direction from the counter table
	branch_dir_predictor u_bdp (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_rd_idx  (bht_idx),
		.o_taken   (pred_taken),
		.i_resolve (i_resolve)
	);

	// Target from the returned word itself
	branch_target_calc u_btc (
		.i_rsp       (i_imem_rsp),
		.o_is_branch (is_branch),
		.o_is_jal    (is_jal),
		.o_target    (target)
	);

	fetch_sequencer u_seq (
		.clk              (clk),
		.rst_n            (rst_n),
		.o_imem_req       (o_imem_req),
		.o_imem_req_valid (o_imem_req_valid),
		.i_imem_rsp       (i_imem_rsp),
		.i_imem_rsp_valid (i_imem_rsp_valid),
		.i_dec_credit     (i_dec_credit),
		.o_fetch          (o_fetch),
		.o_fetch_valid    (o_fetch_valid),
		.i_redirect       (i_redirect),
		.o_bht_idx        (bht_idx),
		.i_pred_taken     (pred_taken),
		.i_is_branch      (is_branch),
		.i_is_jal         (is_jal),
		.i_target         (target)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f compile.f --top-module fetch_tb -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vfetch_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

//--- tests/fetch_chk.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_chk #(
	parameter int W = $clog2(`FETCH_MEM_CREDITS + 1)
) (
	input wire         clk,
	input wire         rst_n,
	input wire         i_req_valid,
	input wire         i_rsp_valid,
	input wire         i_fwd,
	input wire [W-1:0] i_dec_credits,
	input wire         i_fetch_valid
);

	localparam logic [W-1:0] MEM_SLOTS = W'(`FETCH_MEM_CREDITS);

	// Failures seen so far, read back at the end of the run
	int fail_count = 0;

	// Requests memory has not answered yet
	logic [W-1:0] outstanding;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outstanding <= '0;
		end else begin
			case ({i_req_valid, i_rsp_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// Memory request needs a free slot
	a_mem_credit: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_req_valid |-> (outstanding < MEM_SLOTS)
	) else begin
		$error("memory request issued with zero memory credits");
		fail_count++;
	end

	// Forwarded word needs a decode slot
	a_dec_credit: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_fwd |-> (i_dec_credits != '0)
	) else begin
		$error("word forwarded with zero decode credits");
		fail_count++;
	end

	// Output stays quiet once reset has been seen for a full cycle
	a_reset_quiet: assert property (
		@(posedge clk) (!rst_n && !$past(rst_n)) |-> !i_fetch_valid
	) else begin
		$error("fetch output valid during reset");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_tb
	import fetch_pkg::*;
();

	localparam int VEC_WORDS = 1024;
	localparam int RST_CYCLES = 5;

	// One line of the vector file
	typedef struct packed {
		logic [31:0] kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
	} rec_t;

	// Request waiting in the memory model
	typedef struct packed {
		logic [31:0] ready;
		imem_req_t   req;
	} pend_t;

	logic       clk;
	logic       rst_n;
	imem_req_t  imem_req;
	logic       imem_req_valid;
	imem_rsp_t  imem_rsp;
	logic       imem_rsp_valid;
	logic       dec_credit;
	fetch_out_t fetch;
	logic       fetch_valid;
	redirect_t  redirect;
	resolve_t   resolve;

	logic [31:0] vec [VEC_WORDS];
	logic [31:0] mem [logic [31:0]];
	rec_t        exp_q[$];
	rec_t        redir_q[$];
	rec_t        resolve_q[$];
	rec_t        hold_q[$];
	pend_t       mem_q[$];
	int          credit_q[$];
	int          vp;
	int          cycle;
	int          n_out;
	int          errors;
	int          n_tests;
	int          failed_tests;
	int          wd_cycles;
	int          limit = 1000000;
	int          hold_until;
	int          credits_given;
	logic [31:0] last_ready;

	fetch_top dut0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.o_imem_req       (imem_req),
		.o_imem_req_valid (imem_req_valid),
		.i_imem_rsp       (imem_rsp),
		.i_imem_rsp_valid (imem_rsp_valid),
		.i_dec_credit     (dec_credit),
		.o_fetch          (fetch),
		.o_fetch_valid    (fetch_valid),
		.i_redirect       (redirect),
		.i_resolve        (resolve)
	);

	// Credit and reset rules, checked inside the sequencer
	bind fetch_sequencer fetch_chk chk0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_req_valid   (o_imem_req_valid),
		.i_rsp_valid   (i_imem_rsp_valid),
		.i_fwd         (fwd),
		.i_dec_credits (dec_credits),
		.i_fetch_valid (o_fetch_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	function automatic rec_t rec_at(input int idx);
		return {vec[idx*4], vec[idx*4+1], vec[idx*4+2], vec[idx*4+3]};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		// Unloaded words are OP-IMM, never seen by predecode
		return {addr[31:7] ^ {18'd0, addr[6:0]}, 7'h13};
	endfunction

	task automatic drive_idle();
		imem_rsp_valid = 1'b0;
		dec_credit = 1'b0;
		redirect = '0;
		resolve = '0;
	endtask

	// Sort one test's records into the model queues
	task automatic load_test();
		rec_t r;
		mem.delete();
		exp_q.delete();
		redir_q.delete();
		resolve_q.delete();
		hold_q.delete();
		vp++;
		r = rec_at(vp);
		while (r.kind > 1 && r.kind < 7) begin
			case (r.kind)
				3: redir_q.push_back(r);
				4: resolve_q.push_back(r);
				6: hold_q.push_back(r);
				5: begin
					exp_q.push_back(r);
					mem[r.a] = r.b;
				end
				default: mem[r.a] = r.b;
			endcase
			vp++;
			r = rec_at(vp);
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		drive_idle();
		mem_q.delete();
		credit_q.delete();
		n_out = 0;
		hold_until = 0;
		credits_given = 0;
		last_ready = '0;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// One clock of the memory, decode and execute models
	task automatic step();
		pend_t p;
		rec_t  e;
		@(negedge clk);
		cycle++;
		// Registered output, settled at the falling edge
		if (fetch_valid) begin
			e = exp_q[n_out];
			check_value("o_fetch.pc", fetch.pc, e.a);
			check_value("o_fetch.instr", fetch.instr, e.b);
			check_value("o_fetch.pred_taken", 32'(fetch.pred_taken), e.c);
			n_out++;
			// Each word needs a decode slot, either initial or handed back
			if (n_out > `FETCH_DEC_CREDITS + credits_given) begin
				$display("decode output %0d arrived with no decode credit left", n_out - 1);
				errors++;
			end
			credit_q.push_back(cycle + int'($urandom_range(1, 3)));
		end
		drive_idle();
		if (hold_q.size() != 0 && n_out >= int'(hold_q[0].a)) begin
			hold_until = cycle + int'(hold_q[0].b);
			void'(hold_q.pop_front());
		end
		if (cycle >= hold_until && credit_q.size() != 0 && credit_q[0] <= cycle) begin
			dec_credit = 1'b1;
			credits_given++;
			void'(credit_q.pop_front());
		end
		// In-order memory, at most one word per cycle
		if (mem_q.size() != 0 && mem_q[0].ready <= cycle) begin
			p = mem_q.pop_front();
			imem_rsp.instr = read_word(p.req.pc);
			imem_rsp.pc = p.req.pc;
			imem_rsp.epoch = p.req.epoch;
			imem_rsp_valid = 1'b1;
		end
		// Request goes out at the coming rising edge
		if (imem_req_valid) begin
			p.ready = cycle + $urandom_range(1, 4);
			if (p.ready <= last_ready) begin
				p.ready = last_ready + 1;
			end
			last_ready = p.ready;
			p.req = imem_req;
			mem_q.push_back(p);
		end
		// Execute events, tied to the output count
		if (redir_q.size() != 0 && n_out >= int'(redir_q[0].a)) begin
			redirect.valid = 1'b1;
			redirect.trap = redir_q[0].c[0];
			redirect.target = redir_q[0].b;
			void'(redir_q.pop_front());
		end
		if (resolve_q.size() != 0 && n_out >= int'(resolve_q[0].a)) begin
			resolve.valid = 1'b1;
			resolve.pc = resolve_q[0].b;
			resolve.taken = resolve_q[0].c[0];
			void'(resolve_q.pop_front());
		end
	endtask

	task automatic run_test();
		rec_t r;
		int   err0;
		r = rec_at(vp);
		err0 = errors;
		load_test();
		apply_reset();
		while (n_out < exp_q.size()) begin
			step();
		end
		n_tests++;
		if (errors == err0) begin
			$display("test %0d: pass, %0d outputs", r.a, n_out);
		end else begin
			$display("test %0d: FAIL, %0d mismatches", r.a, errors - err0);
			failed_tests++;
		end
	endtask

	initial begin
		rec_t r;
		int   total;
		int   i;
		rst_n = 1'b0;
		imem_rsp = '0;
		drive_idle();
		void'($urandom(31));
		for (i = 0; i < VEC_WORDS; i++) begin
			vec[i] = '0;
		end
		$readmemh("tests/fetch_vectors.txt", vec);
		// Cycle budget from expected outputs, holds and resets
		total = 0;
		for (i = 0; i < VEC_WORDS / 4; i++) begin
			r = rec_at(i);
			if (r.kind == 5) begin
				total += 4 * 8;
			end else if (r.kind == 6) begin
				total += int'(r.b);
			end else if (r.kind == 1) begin
				total += 2 * RST_CYCLES;
			end
		end
		limit = total;
		vp = 0;
		r = rec_at(vp);
		while (r.kind == 1) begin
			run_test();
			r = rec_at(vp);
		end
		if (dut0.u_seq.chk0.fail_count != 0) begin
			$display("%0d assertion failures in the bound checker", dut0.u_seq.chk0.fail_count);
			errors++;
		end
		$display("%0d tests run, %0d failed, %0d errors", n_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wd_cycles = 0;
		@(posedge clk);
		while (wd_cycles < limit) begin
			@(posedge clk);
			wd_cycles++;
		end
		$display("timeout, run still going after %0d cycles", wd_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/fetch_vectors.txt
// Columns: kind a b c, hex, one record per line
// kind 1 test id, 2 word addr data, 3 redirect after_n target trap, 4 resolve after_n pc taken
// kind 5 expected pc instr pred (also loads the word), 6 hold credits after_n cycles, 0 end
// Straight-line code
1 1 0 0
5 00000000 00100093 0
5 00000004 00200113 0
5 00000008 00300193 0
5 0000000c 00400213 0
// JAL at 08 to 20
1 2 0 0
5 00000000 00100093 0
5 00000004 00200113 0
5 00000008 0180006f 1
5 00000020 00700393 0
5 00000024 00800413 0
// Backward branch at 0c, trained taken after first pass
1 3 0 0
5 00000000 00100093 0
5 00000004 00200113 0
5 00000008 00300193 0
5 0000000c fe000ce3 0
5 00000004 00200113 0
5 00000008 00300193 0
5 0000000c fe000ce3 1
5 00000004 00200113 0
3 4 00000004 0
4 4 0000000c 1
4 4 0000000c 1
// Trap then branch redirect
1 4 0 0
5 00000000 00100093 0
5 00000004 00200113 0
5 00000040 00900493 0
5 00000044 00a00513 0
5 00000080 00b00593 0
3 2 00000040 1
3 4 00000080 0
// Decode credits withheld
1 5 0 0
5 00000000 00100093 0
5 00000004 00200113 0
5 00000008 00300193 0
5 0000000c 00400213 0
5 00000010 00500293 0
6 1 18 0
0 0 0 0
